// ==== compile.f ====
design/video_mode_pkg.sv
design/buffer_pkg.sv
design/raster_if.sv
design/fb_writer.sv
design/frame_buffer.sv
design/display_timing.sv
design/pixel_out.sv
design/video_display_top.sv
test/tb_video_display.sv

// ==== Makefile ====
# Verilator build and run of the display subsystem testbench

SRCS := $(wildcard design/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_video_display

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_video_display: compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_video_display -f compile.f

# Exit status of the simulator gives pass or fail
run: obj_dir/Vtb_video_display
	./obj_dir/Vtb_video_display

clean:
	rm -rf obj_dir

// ==== test/tb_video_display.sv ====
// Testbench for the display subsystem with random writes, clears and a frame model
// checked at the VGA outputs every clock

`timescale 1ns/1ps

module tb_video_display
    import video_mode_pkg::*;
    import buffer_pkg::*;
();

    // Small mode giving 44 by 28 clocks per frame, hsync active low, vsync active high
    localparam video_mode_t TEST_MODE = '{
        h_resolution:  16'd36,
        h_front_porch: 16'd2,
        h_sync:        16'd4,
        h_back_porch:  16'd2,
        v_resolution:  16'd24,
        v_front_porch: 16'd1,
        v_sync:        16'd2,
        v_back_porch:  16'd1,
        h_sync_pol:    1'b0,
        v_sync_pol:    1'b1
    };
    localparam buffer_config_t TEST_BUFFER = '{width: 16'd9, height: 16'd6, addr_width: 16'd6};
    localparam bit FLIP = 1'b1;

    localparam int H_RES    = int'(TEST_MODE.h_resolution);
    localparam int V_RES    = int'(TEST_MODE.v_resolution);
    localparam int H_TOTAL  = H_RES + int'(TEST_MODE.h_front_porch) + int'(TEST_MODE.h_sync)
                            + int'(TEST_MODE.h_back_porch);
    localparam int V_TOTAL  = V_RES + int'(TEST_MODE.v_front_porch) + int'(TEST_MODE.v_sync)
                            + int'(TEST_MODE.v_back_porch);
    localparam int HS_FIRST = H_RES + int'(TEST_MODE.h_front_porch) - 1;
    localparam int VS_FIRST = V_RES + int'(TEST_MODE.v_front_porch) - 1;
    localparam int BUF_W    = int'(TEST_BUFFER.width);
    localparam int BUF_H    = int'(TEST_BUFFER.height);
    localparam int DEPTH    = BUF_W * BUF_H;
    localparam int FRAME_CLOCKS   = H_TOTAL * V_TOTAL;
    // Twelve frames of tests, one clear, one frame of slack
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CLOCKS + DEPTH + FRAME_CLOCKS;
    localparam bit [31:0] SEED    = 32'h904a_3696;

    // Expected output for one raster position
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   data_enable;
        logic   check_pix;
        color_t color;
    } expect_t;

    logic        clk_pixel;
    logic        rstn_pixel;
    logic        wr_stb;
    logic [15:0] wr_x;
    logic [15:0] wr_y;
    color_t      wr_color;
    logic        clear_stb;
    color_t      clear_color;
    logic        busy;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        data_enable;
    logic [4:0]  vga_red;
    logic [5:0]  vga_green;
    logic [4:0]  vga_blue;

    color_t      model_mem [DEPTH];
    bit          known [DEPTH];
    expect_t     hist [3];
    int          mx;
    int          my;
    int          frame_idx;
    int          dirty_frame = -10;
    int          busy_left;
    int          cycle_count = 0;
    int          pixel_checks = 0;
    bit          checks_on = 1'b0;

    video_display_top #(
        .VIDEO_MODE   (TEST_MODE),
        .BUFFER_CONFIG(TEST_BUFFER),
        .FLIP_VERTICAL(FLIP)
    ) u_video_display_top (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .wr_stb     (wr_stb),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_color   (wr_color),
        .clear_stb  (clear_stb),
        .clear_color(clear_color),
        .busy       (busy),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .data_enable(data_enable),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #20 clk_pixel = ~clk_pixel;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sync(input string name, input bit expected, input logic actual);
        if (actual !== expected) begin
            report_error($sformatf("Mismatch on %s: expected 0x%h, got 0x%h",
                                   name, expected, actual));
        end
    endtask

    task automatic check_busy(input bit expected, input logic actual);
        if (actual !== expected) begin
            report_error($sformatf("Mismatch on busy: expected 0x%h, got 0x%h", expected, actual));
        end
    endtask

    task automatic check_color(input string name, input color_t expected, input logic [15:0] actual);
        logic [15:0] want;
        // Red and blue gain one low bit, green gains two
        want = {expected.red, 1'b0, expected.green, 2'b00, expected.blue, 1'b0};
        if (actual !== want) begin
            report_error($sformatf("Mismatch on %s: expected 0x%h, got 0x%h", name, want, actual));
        end
    endtask

    function automatic expect_t idle_expect();
        expect_t e;
        e = '0;
        e.hsync = !TEST_MODE.h_sync_pol;
        e.vsync = !TEST_MODE.v_sync_pol;
        e.check_pix = 1'b1;
        return e;
    endfunction

    function automatic expect_t expect_at(int x, int y);
        expect_t e;
        bit      h_act;
        bit      v_act;
        int      row;
        int      addr;
        h_act = (x >= HS_FIRST) && (x < HS_FIRST + int'(TEST_MODE.h_sync));
        v_act = (y >= VS_FIRST) && (y < VS_FIRST + int'(TEST_MODE.v_sync));
        e.hsync = TEST_MODE.h_sync_pol ? h_act : !h_act;
        e.vsync = TEST_MODE.v_sync_pol ? v_act : !v_act;
        e.data_enable = (x < H_RES) && (y < V_RES);
        e.color = '0;
        e.check_pix = 1'b1;
        if (e.data_enable) begin
            // Buffer row 0 sits at the bottom when flipped
            row = FLIP ? (V_RES - 1 - y) : y;
            addr = (row / (V_RES / BUF_H)) * BUF_W + x / (H_RES / BUF_W);
            e.color = model_mem[addr];
            e.check_pix = known[addr] && (frame_idx >= dirty_frame + 2);
        end
        return e;
    endfunction

    // Frame model, sees the same pre-edge inputs as the DUT
    always @(posedge clk_pixel) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout: tests did not finish within %0d cycles",
                                   TIMEOUT_CYCLES));
        end
        if (!rstn_pixel) begin
            mx = 0;
            my = 0;
            frame_idx = 0;
            busy_left = 0;
            for (int i = 0; i < 3; i++) begin
                hist[i] = idle_expect();
            end
        end else begin
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = expect_at(mx, my);
            if (busy_left > 0) begin
                busy_left--;
                dirty_frame = frame_idx;
            end else if (clear_stb) begin
                busy_left = DEPTH;
                dirty_frame = frame_idx;
                for (int i = 0; i < DEPTH; i++) begin
                    model_mem[i] = clear_color;
                    known[i] = 1'b1;
                end
            end else if (wr_stb && (int'(wr_x) < BUF_W) && (int'(wr_y) < BUF_H)) begin
                model_mem[int'(wr_y) * BUF_W + int'(wr_x)] = wr_color;
                known[int'(wr_y) * BUF_W + int'(wr_x)] = 1'b1;
                dirty_frame = frame_idx;
            end
            if (mx == H_TOTAL - 1) begin
                mx = 0;
                if (my == V_TOTAL - 1) begin
                    my = 0;
                    frame_idx++;
                end else begin
                    my++;
                end
            end else begin
                mx++;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_pixel) begin
        if (checks_on) begin
            check_sync("vga_hsync", hist[2].hsync, vga_hsync);
            check_sync("vga_vsync", hist[2].vsync, vga_vsync);
            check_sync("data_enable", hist[2].data_enable, data_enable);
            check_busy(busy_left > 0, busy);
            if (hist[2].check_pix) begin
                check_color("vga_rgb", hist[2].color, {vga_red, vga_green, vga_blue});
                if (hist[2].data_enable) begin
                    pixel_checks++;
                end
            end
        end
    end

    task automatic write_pixel(input logic [15:0] x, input logic [15:0] y, input color_t color);
        @(posedge clk_pixel);
        wr_stb   <= 1'b1;
        wr_x     <= x;
        wr_y     <= y;
        wr_color <= color;
        @(posedge clk_pixel);
        wr_stb <= 1'b0;
    endtask

    task automatic random_writes(input int count, input bit in_range);
        logic [15:0] x;
        logic [15:0] y;
        int          kind;
        for (int n = 0; n < count; n++) begin
            x = 16'($urandom % BUF_W);
            y = 16'($urandom % BUF_H);
            kind = $urandom % 3;
            // Kind 0 breaks x, kind 1 breaks y, kind 2 breaks both
            if (!in_range && kind != 1) begin
                x = 16'(BUF_W + ($urandom % (65536 - BUF_W)));
            end
            if (!in_range && kind != 0) begin
                y = 16'(BUF_H + ($urandom % (65536 - BUF_H)));
            end
            write_pixel(x, y, color_t'(12'($urandom)));
            repeat ($urandom % 3) @(posedge clk_pixel);
        end
    endtask

    // Returns once a whole frame after the stimulus has been checked
    task automatic wait_checked_frame();
        int target;
        @(negedge clk_pixel);
        target = frame_idx + 3;
        while (frame_idx < target) begin
            @(negedge clk_pixel);
        end
        repeat (4) @(negedge clk_pixel);
    endtask

    task automatic clear_with_strobes();
        int busy_cycles;
        bit done;
        busy_cycles = 0;
        done = 1'b0;
        @(posedge clk_pixel);
        clear_stb   <= 1'b1;
        clear_color <= color_t'(12'($urandom));
        @(posedge clk_pixel);
        clear_stb <= 1'b0;
        while (!done) begin
            @(negedge clk_pixel);
            if (!busy) begin
                done = 1'b1;
            end else begin
                busy_cycles++;
                if (busy_cycles > 2 * DEPTH) begin
                    report_error("busy stayed high far longer than one clear");
                end
                @(posedge clk_pixel);
                // Strobes landing inside the sweep
                wr_stb    <= (busy_cycles <= 50);
                clear_stb <= (busy_cycles <= 50) && 1'($urandom);
                wr_x      <= 16'($urandom % BUF_W);
                wr_y      <= 16'($urandom % BUF_H);
                wr_color  <= color_t'(12'($urandom));
            end
        end
        if (busy_cycles != DEPTH) begin
            report_error($sformatf("Mismatch on busy_cycles: expected 0x%h, got 0x%h",
                                   DEPTH, busy_cycles));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rstn_pixel  = 1'b0;
        wr_stb      = 1'b0;
        wr_x        = '0;
        wr_y        = '0;
        wr_color    = '0;
        clear_stb   = 1'b0;
        clear_color = '0;
        @(posedge clk_pixel);
        checks_on = 1'b1;
        repeat (2) @(posedge clk_pixel);
        rstn_pixel <= 1'b1;

        random_writes(40, 1'b1);
        wait_checked_frame();
        random_writes(15, 1'b0);
        wait_checked_frame();
        clear_with_strobes();
        wait_checked_frame();
        random_writes(20, 1'b1);
        wait_checked_frame();

        if (pixel_checks == 0) begin
            report_error("No visible pixel was ever compared with the model");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== design/video_display_top.sv ====
// Display subsystem top with writer, frame buffer, raster timing and pixel output

`timescale 1ns/1ps

module video_display_top
    import video_mode_pkg::*;
    import buffer_pkg::*;
#(
    parameter video_mode_t    VIDEO_MODE    = VMODE_640x480p60,
    parameter buffer_config_t BUFFER_CONFIG = BUFFER_160x120x12,
    parameter bit             FLIP_VERTICAL = 1'b0
) (
    input  logic        clk_pixel,
    input  logic        rstn_pixel,
    input  logic        wr_stb,
    input  logic [15:0] wr_x,
    input  logic [15:0] wr_y,
    input  color_t      wr_color,
    input  logic        clear_stb,
    input  color_t      clear_color,
    output logic        busy,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        data_enable,
    output logic [4:0]  vga_red,
    output logic [5:0]  vga_green,
    output logic [4:0]  vga_blue
);

    localparam int AW = int'(BUFFER_CONFIG.addr_width);

    logic          wr_en;
    logic [AW-1:0] wr_addr;
    color_t        wr_data;
    logic [AW-1:0] rd_addr;
    color_t        rd_data;

    raster_if #(
        .X_WIDTH(raster_x_width(VIDEO_MODE)),
        .Y_WIDTH(raster_y_width(VIDEO_MODE))
    ) raster ();

    fb_writer #(
        .BUFFER_CONFIG(BUFFER_CONFIG)
    ) u_fb_writer (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .wr_stb     (wr_stb),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_color   (wr_color),
        .clear_stb  (clear_stb),
        .clear_color(clear_color),
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    frame_buffer #(
        .DEPTH     (buffer_depth(BUFFER_CONFIG)),
        .ADDR_WIDTH(AW),
        .payload_t (color_t)
    ) u_frame_buffer (
        .clk_pixel(clk_pixel),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    display_timing #(
        .VIDEO_MODE(VIDEO_MODE)
    ) u_display_timing (
        .clk_pixel (clk_pixel),
        .rstn_pixel(rstn_pixel),
        .raster    (raster.source)
    );

    pixel_out #(
        .VIDEO_MODE   (VIDEO_MODE),
        .BUFFER_CONFIG(BUFFER_CONFIG),
        .FLIP_VERTICAL(FLIP_VERTICAL)
    ) u_pixel_out (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .raster     (raster.sink),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .data_enable(data_enable),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

endmodule

// ==== design/pixel_out.sv ====
// Buffer address scaling and flip, 5-6-5 colour expansion and
// the three-stage output pipeline

`timescale 1ns/1ps

module pixel_out
    import video_mode_pkg::*;
    import buffer_pkg::*;
#(
    parameter video_mode_t    VIDEO_MODE    = VMODE_640x480p60,
    parameter buffer_config_t BUFFER_CONFIG = BUFFER_160x120x12,
    parameter bit             FLIP_VERTICAL = 1'b0
) (
    input  logic                                clk_pixel,
    input  logic                                rstn_pixel,
    raster_if.sink                              raster,
    input  color_t                              rd_data,
    output logic [BUFFER_CONFIG.addr_width-1:0] rd_addr,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                data_enable,
    output logic [4:0]                          vga_red,
    output logic [5:0]                          vga_green,
    output logic [4:0]                          vga_blue
);

    localparam int H_RES = int'(VIDEO_MODE.h_resolution);
    localparam int V_RES = int'(VIDEO_MODE.v_resolution);
    localparam int WIDTH = int'(BUFFER_CONFIG.width);
    localparam int AW    = int'(BUFFER_CONFIG.addr_width);
    // Screen pixels per buffer pixel, as a power of two
    localparam int SCALE = $clog2(H_RES / WIDTH);

    // Sync and enable as {hsync, vsync, data_enable}
    localparam logic [2:0] CTRL_IDLE = {!VIDEO_MODE.h_sync_pol, !VIDEO_MODE.v_sync_pol, 1'b0};

    int         src_y;
    int         buf_x;
    int         buf_y;
    logic [2:0] ctrl_s1;
    logic [2:0] ctrl_s2;
    logic [4:0] red_exp;
    logic [5:0] green_exp;
    logic [4:0] blue_exp;

    // Mirror about the visible height, then scale down to buffer pixels
    always_comb begin
        src_y = FLIP_VERTICAL ? (V_RES - 1 - int'(raster.y)) : int'(raster.y);
        buf_x = int'(raster.x) >> SCALE;
        buf_y = src_y >> SCALE;
    end

    // Stage 1 registers the address, stage 2 waits on the RAM
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            rd_addr <= '0;
            ctrl_s1 <= CTRL_IDLE;
            ctrl_s2 <= CTRL_IDLE;
        end else begin
            rd_addr <= raster.data_enable ? AW'(buf_y * WIDTH + buf_x) : '0;
            ctrl_s1 <= {raster.hsync, raster.vsync, raster.data_enable};
            ctrl_s2 <= ctrl_s1;
        end
    end

    // Black outside the visible area
    always_comb begin
        red_exp   = ctrl_s2[0] ? {rd_data.red, 1'b0}    : 5'd0;
        green_exp = ctrl_s2[0] ? {rd_data.green, 2'b00} : 6'd0;
        blue_exp  = ctrl_s2[0] ? {rd_data.blue, 1'b0}   : 5'd0;
    end

    // Stage 3 drives the pins
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            vga_hsync   <= CTRL_IDLE[2];
            vga_vsync   <= CTRL_IDLE[1];
            data_enable <= 1'b0;
            vga_red     <= '0;
            vga_green   <= '0;
            vga_blue    <= '0;
        end else begin
            vga_hsync   <= ctrl_s2[2];
            vga_vsync   <= ctrl_s2[1];
            data_enable <= ctrl_s2[0];
            vga_red     <= red_exp;
            vga_green   <= green_exp;
            vga_blue    <= blue_exp;
        end
    end

endmodule

// ==== design/display_timing.sv ====
// Raster counters with sync window and data enable decode

`timescale 1ns/1ps

module display_timing
    import video_mode_pkg::*;
#(
    parameter video_mode_t VIDEO_MODE = VMODE_640x480p60
) (
    input  logic     clk_pixel,
    input  logic     rstn_pixel,
    raster_if.source raster
);

    localparam int H_RES   = int'(VIDEO_MODE.h_resolution);
    localparam int V_RES   = int'(VIDEO_MODE.v_resolution);
    localparam int H_TOTAL = h_total(VIDEO_MODE);
    localparam int V_TOTAL = v_total(VIDEO_MODE);
    localparam int XW      = raster_x_width(VIDEO_MODE);
    localparam int YW      = raster_y_width(VIDEO_MODE);

    // Sync windows start one clock before the end of the front porch
    localparam int HS_START = H_RES + int'(VIDEO_MODE.h_front_porch) - 1;
    localparam int HS_END   = HS_START + int'(VIDEO_MODE.h_sync);
    localparam int VS_START = V_RES + int'(VIDEO_MODE.v_front_porch) - 1;
    localparam int VS_END   = VS_START + int'(VIDEO_MODE.v_sync);

    logic [XW-1:0] x_q;
    logic [YW-1:0] y_q;
    logic          h_active;
    logic          v_active;

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_q == XW'(H_TOTAL - 1)) begin
            x_q <= '0;
            if (y_q == YW'(V_TOTAL - 1)) begin
                y_q <= '0;
            end else begin
                y_q <= y_q + 1'b1;
            end
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    always_comb begin
        h_active = (int'(x_q) >= HS_START) && (int'(x_q) < HS_END);
        v_active = (int'(y_q) >= VS_START) && (int'(y_q) < VS_END);
    end

    assign raster.x           = x_q;
    assign raster.y           = y_q;
    assign raster.hsync       = VIDEO_MODE.h_sync_pol ? h_active : !h_active;
    assign raster.vsync       = VIDEO_MODE.v_sync_pol ? v_active : !v_active;
    assign raster.data_enable = (int'(x_q) < H_RES) && (int'(y_q) < V_RES);

endmodule

// ==== design/frame_buffer.sv ====
// Simple dual-port RAM, one write port and one registered read port

`timescale 1ns/1ps

module frame_buffer #(
    parameter int  DEPTH      = 19200,
    parameter int  ADDR_WIDTH = 15,
    parameter type payload_t  = logic [11:0]
) (
    input  logic                  clk_pixel,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  payload_t              wr_data,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output payload_t              rd_data
);

    payload_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data appears one clock after the address
    always_ff @(posedge clk_pixel) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== design/fb_writer.sv ====
// Frame buffer write stage for pixel strobes and the clear sequencer

`timescale 1ns/1ps

module fb_writer
    import buffer_pkg::*;
#(
    parameter buffer_config_t BUFFER_CONFIG = BUFFER_160x120x12
) (
    input  logic                                clk_pixel,
    input  logic                                rstn_pixel,
    input  logic                                wr_stb,
    input  logic [15:0]                         wr_x,
    input  logic [15:0]                         wr_y,
    input  color_t                              wr_color,
    input  logic                                clear_stb,
    input  color_t                              clear_color,
    output logic                                busy,
    output logic                                wr_en,
    output logic [BUFFER_CONFIG.addr_width-1:0] wr_addr,
    output color_t                              wr_data
);

    localparam int WIDTH  = int'(BUFFER_CONFIG.width);
    localparam int HEIGHT = int'(BUFFER_CONFIG.height);
    localparam int AW     = int'(BUFFER_CONFIG.addr_width);
    localparam logic [AW-1:0] LAST_ADDR = AW'(buffer_depth(BUFFER_CONFIG) - 1);

    typedef enum logic {
        ST_IDLE,
        ST_CLEAR
    } state_t;

    state_t        state;
    logic          pixel_ok;
    logic          clear_start;
    logic [AW-1:0] pixel_addr;

    // Strobes only count while idle; a clear wins over a pixel in the same cycle
    assign clear_start = (state == ST_IDLE) && clear_stb;
    assign pixel_ok    = (state == ST_IDLE) && !clear_stb && wr_stb
                       && (int'(wr_x) < WIDTH) && (int'(wr_y) < HEIGHT);
    assign pixel_addr  = AW'(int'(wr_y) * WIDTH + int'(wr_x));
    assign busy        = (state == ST_CLEAR);

    // The write address doubles as the clear counter
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            state   <= ST_IDLE;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (clear_start) begin
                        state   <= ST_CLEAR;
                        wr_en   <= 1'b1;
                        wr_addr <= '0;
                    end else begin
                        wr_en   <= pixel_ok;
                        wr_addr <= pixel_addr;
                    end
                end
                ST_CLEAR: begin
                    if (wr_addr == LAST_ADDR) begin
                        state <= ST_IDLE;
                        wr_en <= 1'b0;
                    end else begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    wr_en <= 1'b0;
                end
            endcase
        end
    end

    // Clear colour is held here for the whole sweep
    always_ff @(posedge clk_pixel) begin
        if (clear_start) begin
            wr_data <= clear_color;
        end else if (state == ST_IDLE) begin
            wr_data <= wr_color;
        end
    end

endmodule

// ==== design/raster_if.sv ====
// Raster bundle between the timing generator and the pixel output stage

`timescale 1ns/1ps

interface raster_if #(
    parameter int X_WIDTH = 10,
    parameter int Y_WIDTH = 10
) ();

    logic [X_WIDTH-1:0] x;
    logic [Y_WIDTH-1:0] y;
    // Syncs carry the polarity of the mode
    logic               hsync;
    logic               vsync;
    logic               data_enable;

    modport source (output x, y, hsync, vsync, data_enable);

    modport sink (input x, y, hsync, vsync, data_enable);

endinterface

// ==== design/buffer_pkg.sv ====
// Frame buffer configuration record, 12-bit colour type and standard buffer constants

package buffer_pkg;

    // Buffer geometry in buffer pixels
    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
        logic [15:0] addr_width;
    } buffer_config_t;

    // Colour as stored in the buffer, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    // Quarter resolution of 640x480, 19200 words
    localparam buffer_config_t BUFFER_160x120x12 = '{
        width:      16'd160,
        height:     16'd120,
        addr_width: 16'd15
    };

    // Number of words in the buffer
    function automatic int buffer_depth(buffer_config_t cfg);
        return int'(cfg.width) * int'(cfg.height);
    endfunction

endpackage

// ==== design/video_mode_pkg.sv ====
// Video mode record, standard mode constants and raster size helpers

package video_mode_pkg;

    // Horizontal and vertical timing of one video mode
    typedef struct packed {
        logic [15:0] h_resolution;
        logic [15:0] h_front_porch;
        logic [15:0] h_sync;
        logic [15:0] h_back_porch;
        logic [15:0] v_resolution;
        logic [15:0] v_front_porch;
        logic [15:0] v_sync;
        logic [15:0] v_back_porch;
        logic        h_sync_pol;
        logic        v_sync_pol;
    } video_mode_t;

    // Industry standard 640x480 at 60 Hz, both syncs active low
    localparam video_mode_t VMODE_640x480p60 = '{
        h_resolution:  16'd640,
        h_front_porch: 16'd16,
        h_sync:        16'd96,
        h_back_porch:  16'd48,
        v_resolution:  16'd480,
        v_front_porch: 16'd10,
        v_sync:        16'd2,
        v_back_porch:  16'd33,
        h_sync_pol:    1'b0,
        v_sync_pol:    1'b0
    };

    // Clocks per line, including blanking
    function automatic int h_total(video_mode_t mode);
        return int'(mode.h_resolution) + int'(mode.h_front_porch)
             + int'(mode.h_sync) + int'(mode.h_back_porch);
    endfunction

    // Lines per frame, including blanking
    function automatic int v_total(video_mode_t mode);
        return int'(mode.v_resolution) + int'(mode.v_front_porch)
             + int'(mode.v_sync) + int'(mode.v_back_porch);
    endfunction

    // Counter widths that hold 0 to total minus 1
    function automatic int raster_x_width(video_mode_t mode);
        return $clog2(h_total(mode));
    endfunction

    function automatic int raster_y_width(video_mode_t mode);
        return $clog2(v_total(mode));
    endfunction

endpackage
